//--- bench/l1d_tb.sv
`default_nettype none

`include "l1d_config.svh"

module l1d_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_requests    = 32;
    localparam int miss_cycles     = 2 * (`L1D_L2_MAX_LAT + 4) + 8;   // Write-back plus refill
    localparam int watchdog_cycles = num_requests * miss_cycles + 40;

    // Lines used by the tests, sets 5, 9 and 20
    localparam l1d_pkg::addr_t line_a  = 64'h0000_1000_0000_0140;
    localparam l1d_pkg::addr_t line_b  = 64'h0000_2000_0000_0240;
    localparam l1d_pkg::addr_t line_c0 = 64'h0000_0000_0003_0500;
    localparam l1d_pkg::addr_t line_c1 = 64'h0000_0000_0003_1500;
    localparam l1d_pkg::addr_t line_c2 = 64'h0000_0000_0003_2500;
    localparam l1d_pkg::addr_t line_e  = 64'h0000_4000_0000_0140;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  r_addr_valid;
    logic                  w_valid;
    l1d_pkg::addr_t        r_addr;
    l1d_pkg::addr_t        w_addr;
    l1d_pkg::dword_t       w_data;
    l1d_pkg::access_size_t w_size;
    logic                  l2_r_data_valid;
    l1d_pkg::line_t        l2_r_data;
    logic                  l2_w_complete;
    logic                  req_ready;
    logic                  r_data_valid;
    l1d_pkg::dword_t       r_data;
    logic                  w_complete;
    logic                  l2_r_addr_valid;
    l1d_pkg::addr_t        l2_r_addr;
    logic                  l2_w_valid;
    l1d_pkg::addr_t        l2_w_addr;
    l1d_pkg::line_t        l2_w_data;

    // Reference model of the cache state and of the L2 contents
    l1d_pkg::tag_t         m_tag   [`L1D_WAYS][`L1D_SETS];
    l1d_pkg::line_t        m_line  [`L1D_WAYS][`L1D_SETS];
    bit                    m_valid [`L1D_WAYS][`L1D_SETS];
    bit                    m_dirty [`L1D_WAYS][`L1D_SETS];
    bit                    rr;
    l1d_pkg::line_t        ref_mem [l1d_pkg::addr_t];
    l1d_pkg::addr_t        rd_addr_q [$];   // Refills seen on the L2 bus
    l1d_pkg::addr_t        wb_addr_q [$];
    l1d_pkg::line_t        wb_line_q [$];

    l1d_cache i_l1d_cache (.*);
    l2_model  i_l2_model (.*);

    initial begin
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        abort_run($sformatf("Watchdog expired after %0d cycles, the run is stuck",
                            watchdog_cycles));
    end

    // Registered outputs and model answers are stable at the rising edge
    always @(posedge clk) begin
        if (!reset && l2_r_addr_valid && l2_r_data_valid) begin
            rd_addr_q.push_back(l2_r_addr);
            if (ref_mem.exists(l2_r_addr))
                check_line("l2_r_data", l2_r_data, ref_mem[l2_r_addr]);
            else
                ref_mem[l2_r_addr] = l2_r_data;     // First sight of this line
        end
        if (!reset && l2_w_valid && l2_w_complete) begin
            wb_addr_q.push_back(l2_w_addr);
            wb_line_q.push_back(l2_w_data);
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_dword(input string name, input l1d_pkg::dword_t got,
                               input l1d_pkg::dword_t exp);
        if (got !== exp)
            abort_run($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input l1d_pkg::addr_t got,
                              input l1d_pkg::addr_t exp);
        if (got !== exp)
            abort_run($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_line(input string name, input l1d_pkg::line_t got,
                              input l1d_pkg::line_t exp);
        if (got !== exp)
            abort_run($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic reset_dut();
        reset        = 1'b1;
        r_addr_valid = 1'b0;
        w_valid      = 1'b0;
        r_addr       = '0;
        w_addr       = '0;
        w_data       = '0;
        w_size       = l1d_pkg::size_dword;
        repeat (10) @(negedge clk);
        check_flag("req_ready", req_ready, 1'b0);
        check_flag("r_data_valid", r_data_valid, 1'b0);
        check_flag("w_complete", w_complete, 1'b0);
        check_flag("l2_r_addr_valid", l2_r_addr_valid, 1'b0);
        check_flag("l2_w_valid", l2_w_valid, 1'b0);
        reset = 1'b0;
        for (int w = 0; w < `L1D_WAYS; w++) begin
            for (int s = 0; s < `L1D_SETS; s++) begin
                m_valid[w][s] = 1'b0;
                m_dirty[w][s] = 1'b0;
            end
        end
        rr = 1'b0;
        rd_addr_q.delete();
        wb_addr_q.delete();
        wb_line_q.delete();
        @(negedge clk);
        check_flag("req_ready", req_ready, 1'b1);     // One cycle out of reset
    endtask

    // Caller has raised the valid at this falling edge
    task automatic accept_request(input bit is_write);
        int waited;
        waited = 0;
        while (!req_ready) begin
            @(negedge clk);
            waited++;
            if (waited > miss_cycles)
                abort_run("req_ready stayed low, the request was never accepted");
        end
        @(negedge clk);
        if (is_write) w_valid = 1'b0;
        else r_addr_valid = 1'b0;
    endtask

    task automatic wait_completion(input bit is_write, output int lat);
        lat = 1;
        while (!(is_write ? w_complete : r_data_valid)) begin
            if (is_write ? r_data_valid : w_complete)
                abort_run("Completion pulse on the wrong port");
            if (req_ready)
                abort_run("req_ready went high while a request was in flight");
            @(negedge clk);
            lat++;
            if (lat > miss_cycles)
                abort_run($sformatf("Request not completed after %0d cycles", lat));
        end
    endtask

    task automatic update_model(input bit is_write, input l1d_pkg::addr_t addr,
                                input l1d_pkg::dword_t value,
                                input l1d_pkg::access_size_t size, input int lat);
        int             idx;
        int             off;
        int             way;
        bit             hit;
        l1d_pkg::tag_t  tag;
        l1d_pkg::addr_t base;
        l1d_pkg::addr_t victim_addr;
        idx  = int'(addr[`L1D_OFFSET_W +: `L1D_INDEX_W]);
        off  = int'(addr[`L1D_OFFSET_W-1:0]);
        tag  = addr[`L1D_ADDR_W-1 -: `L1D_TAG_W];
        base = {tag, addr[`L1D_OFFSET_W +: `L1D_INDEX_W], {`L1D_OFFSET_W{1'b0}}};
        hit  = 1'b0;
        way  = 0;
        for (int w = 0; w < `L1D_WAYS; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (hit && lat != 2)
            abort_run($sformatf("Hit at 0x%h took %0d cycles instead of 2", addr, lat));
        if (!hit) begin
            if (!m_valid[0][idx]) way = 0;
            else if (!m_valid[1][idx]) way = 1;
            else way = int'(rr);
            if (m_valid[way][idx] && m_dirty[way][idx]) begin
                if (wb_addr_q.size() == 0)
                    abort_run($sformatf("Miss at 0x%h did not write back its dirty victim", addr));
                victim_addr = {m_tag[way][idx], addr[`L1D_OFFSET_W +: `L1D_INDEX_W],
                               {`L1D_OFFSET_W{1'b0}}};
                check_addr("l2_w_addr", wb_addr_q.pop_front(), victim_addr);
                check_line("l2_w_data", wb_line_q.pop_front(), m_line[way][idx]);
                ref_mem[victim_addr] = m_line[way][idx];
            end
            if (rd_addr_q.size() == 0)
                abort_run($sformatf("Miss at 0x%h finished without an L2 refill", addr));
            check_addr("l2_r_addr", rd_addr_q.pop_front(), base);
            if (m_valid[0][idx] && m_valid[1][idx]) rr = !rr;   // Full set, move the pointer
            m_line[way][idx]  = ref_mem[base];
            m_tag[way][idx]   = tag;
            m_valid[way][idx] = 1'b1;
            m_dirty[way][idx] = 1'b0;
        end
        if (is_write) begin
            for (int b = 0; b < (1 << size); b++) begin
                m_line[way][idx][(off + b) * 8 +: 8] = value[b * 8 +: 8];
            end
            m_dirty[way][idx] = 1'b1;
        end else begin
            check_dword("r_data", value,
                        m_line[way][idx][(off / 8) * `L1D_DWORD_W +: `L1D_DWORD_W]);
        end
        if (rd_addr_q.size() != 0 || wb_addr_q.size() != 0)
            abort_run($sformatf("Request at 0x%h caused an unneeded L2 transfer", addr));
    endtask

    task automatic read_dword(input l1d_pkg::addr_t addr);
        int              lat;
        l1d_pkg::dword_t got;
        r_addr       = addr;
        r_addr_valid = 1'b1;
        accept_request(1'b0);
        wait_completion(1'b0, lat);
        got = r_data;
        update_model(1'b0, addr, got, l1d_pkg::size_dword, lat);
    endtask

    task automatic write_sized(input l1d_pkg::addr_t addr, input l1d_pkg::dword_t data,
                               input l1d_pkg::access_size_t size);
        int lat;
        w_addr  = addr;
        w_data  = data;
        w_size  = size;
        w_valid = 1'b1;
        accept_request(1'b1);
        wait_completion(1'b1, lat);
        update_model(1'b1, addr, data, size, lat);
    endtask

    // Both ports valid together, the write stays valid through the read miss
    task automatic back_pressure(input l1d_pkg::addr_t rd_addr, input l1d_pkg::addr_t wr_addr,
                                 input l1d_pkg::dword_t wr_data);
        int              lat;
        l1d_pkg::dword_t got;
        r_addr       = rd_addr;
        r_addr_valid = 1'b1;
        w_addr       = wr_addr;
        w_data       = wr_data;
        w_size       = l1d_pkg::size_dword;
        w_valid      = 1'b1;
        accept_request(1'b0);
        wait_completion(1'b0, lat);
        got = r_data;
        update_model(1'b0, rd_addr, got, l1d_pkg::size_dword, lat);
        accept_request(1'b1);
        wait_completion(1'b1, lat);
        update_model(1'b1, wr_addr, wr_data, l1d_pkg::size_dword, lat);
    endtask

    initial begin
        reset_dut();
        read_dword(line_a + 8);      // Cold miss
        read_dword(line_a + 8);      // Same dword again, hit
        write_sized(line_a + 9, 64'hffff_ffff_ffff_ffa5, l1d_pkg::size_byte);
        write_sized(line_a + 10, 64'heeee_eeee_eeee_c3d2, l1d_pkg::size_half);
        write_sized(line_a + 12, 64'hdddd_dddd_8bad_f00d, l1d_pkg::size_word);
        write_sized(line_a + 16, 64'h0123_4567_89ab_cdef, l1d_pkg::size_dword);
        read_dword(line_a + 8);
        read_dword(line_a + 16);
        read_dword(line_a + 24);     // Untouched neighbour
        write_sized(line_b + 28, 64'h7777_7777_1357_9bdf, l1d_pkg::size_word);
        read_dword(line_b + 24);
        write_sized(line_c0 + 32, 64'hc0c0_c0c0_0000_0001, l1d_pkg::size_dword);
        write_sized(line_c1 + 8, 64'hc1c1_c1c1_0000_0002, l1d_pkg::size_dword);
        read_dword(line_c2);         // Evicts a dirty line of set 20
        read_dword(line_c0 + 32);    // Evicts the other one, brings back the written data
        back_pressure(line_e + 16, line_e + 48, 64'h5a5a_a5a5_3c3c_c3c3);
        read_dword(line_e + 48);
        reset_dut();
        read_dword(line_a + 8);      // Contents gone after reset, must miss
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/l2_model.sv
`default_nettype none

`include "l1d_config.svh"

module l2_model (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           l2_r_addr_valid,
    input  wire l1d_pkg::addr_t l2_r_addr,
    output logic                l2_r_data_valid,
    output l1d_pkg::line_t      l2_r_data,
    input  wire logic           l2_w_valid,
    input  wire l1d_pkg::addr_t l2_w_addr,
    input  wire l1d_pkg::line_t l2_w_data,
    output logic                l2_w_complete
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int resp_delay = `L1D_L2_MAX_LAT / 4;   // Cycles before each answer

    l1d_pkg::line_t mem [l1d_pkg::addr_t];   // Sparse, filled on first touch
    integer         seed;
    int             rd_wait;
    int             wr_wait;

    function automatic l1d_pkg::line_t fresh_line();
        l1d_pkg::line_t line;
        for (int i = 0; i < `L1D_LINE_W / 32; i++) begin
            line[i*32 +: 32] = $random(seed);
        end
        return line;
    endfunction

    initial begin
        seed            = 32'hcd53_3d4b;
        l2_r_data_valid = 1'b0;
        l2_r_data       = '0;
        l2_w_complete   = 1'b0;
        rd_wait         = 0;
        wr_wait         = 0;
        forever begin
            @(negedge clk);
            if (reset) begin
                l2_r_data_valid = 1'b0;
                l2_w_complete   = 1'b0;
                rd_wait         = 0;
                wr_wait         = 0;
            end else begin
                if (l2_r_data_valid) begin
                    l2_r_data_valid = 1'b0;    // One-cycle answer
                end else if (l2_r_addr_valid) begin
                    if (rd_wait == resp_delay) begin
                        if (!mem.exists(l2_r_addr)) mem[l2_r_addr] = fresh_line();
                        l2_r_data       = mem[l2_r_addr];
                        l2_r_data_valid = 1'b1;
                        rd_wait         = 0;
                    end else begin
                        rd_wait++;
                    end
                end
                if (l2_w_complete) begin
                    l2_w_complete = 1'b0;
                end else if (l2_w_valid) begin
                    if (wr_wait == resp_delay) begin
                        mem[l2_w_addr] = l2_w_data;
                        l2_w_complete  = 1'b1;
                        wr_wait        = 0;
                        $display("L2 write-back at 0x%h, low dword 0x%h",
                                 l2_w_addr, l2_w_data[63:0]);
                    end else begin
                        wr_wait++;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+verilog
verilog/l1d_pkg.sv
verilog/l1d_controller.sv
verilog/l1d_line_store.sv
verilog/l1d_l2_port.sv
verilog/l1d_cache.sv
bench/l2_model.sv
bench/l1d_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the L1 data cache testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module l1d_tb \
    --Mdir obj_dir -o l1d_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/l1d_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi
exit 0

//--- verilog/l1d_cache.sv
`default_nettype none

module l1d_cache (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  r_addr_valid,
    input  wire l1d_pkg::addr_t        r_addr,
    input  wire logic                  w_valid,
    input  wire l1d_pkg::addr_t        w_addr,
    input  wire l1d_pkg::dword_t       w_data,
    input  wire l1d_pkg::access_size_t w_size,
    input  wire logic                  l2_r_data_valid,
    input  wire l1d_pkg::line_t        l2_r_data,
    input  wire logic                  l2_w_complete,
    output logic                       req_ready,
    output logic                       r_data_valid,
    output l1d_pkg::dword_t            r_data,
    output logic                       w_complete,
    output logic                       l2_r_addr_valid,
    output l1d_pkg::addr_t             l2_r_addr,
    output logic                       l2_w_valid,
    output l1d_pkg::addr_t             l2_w_addr,
    output l1d_pkg::line_t             l2_w_data
);

    // Controller to line store
    l1d_pkg::addr_t        lookup_addr;
    logic                  fill_en;
    l1d_pkg::way_t         fill_way;
    logic                  write_en;
    l1d_pkg::way_t         write_way;
    l1d_pkg::dword_t       write_data;
    l1d_pkg::access_size_t write_size;

    // Line store lookup results
    logic                  hit;
    l1d_pkg::way_t         hit_way;
    l1d_pkg::dword_t       hit_dword;
    l1d_pkg::way_t         victim_way;
    logic                  victim_dirty;
    l1d_pkg::tag_t         victim_tag;
    l1d_pkg::line_t        victim_line;

    // Controller and L2 port
    logic                  start_read;
    logic                  start_write;
    l1d_pkg::addr_t        xfer_addr;
    l1d_pkg::line_t        xfer_line;
    logic                  xfer_done;
    l1d_pkg::line_t        fill_line;   // Also the line store's refill data

    l1d_controller i_l1d_controller (.*);

    l1d_line_store i_l1d_line_store (
        .clk, .reset,
        .lookup_addr,
        .fill_en, .fill_way, .fill_line,
        .write_en, .write_way, .write_data, .write_size,
        .hit, .hit_way, .hit_dword,
        .victim_way, .victim_dirty, .victim_tag, .victim_line
    );

    l1d_l2_port i_l1d_l2_port (
        .clk, .reset,
        .start_read, .start_write, .xfer_addr, .xfer_line,
        .l2_r_data_valid, .l2_r_data, .l2_w_complete,
        .l2_r_addr_valid, .l2_r_addr,
        .l2_w_valid, .l2_w_addr, .l2_w_data,
        .xfer_done, .fill_line
    );

endmodule

`default_nettype wire

//--- verilog/l1d_config.svh
`ifndef L1D_CONFIG_SVH
`define L1D_CONFIG_SVH

// Address and core data widths
`define L1D_ADDR_W      64
`define L1D_DWORD_W     64

// Cache geometry
`define L1D_SETS        64
`define L1D_LINE_BYTES  64

// Two ways only, the replacement bit is a single flop
`define L1D_WAYS        2

// Derived address fields
`define L1D_INDEX_W     ($clog2(`L1D_SETS))
`define L1D_OFFSET_W    ($clog2(`L1D_LINE_BYTES))
`define L1D_TAG_W       (`L1D_ADDR_W - `L1D_INDEX_W - `L1D_OFFSET_W)

// Bits per line
`define L1D_LINE_W      (`L1D_LINE_BYTES * 8)

// Longest L2 response time in cycles, one line transfer
`define L1D_L2_MAX_LAT  32

`endif

//--- verilog/l1d_controller.sv
`default_nettype none

`include "l1d_config.svh"

module l1d_controller (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  r_addr_valid,
    input  wire l1d_pkg::addr_t        r_addr,
    input  wire logic                  w_valid,
    input  wire l1d_pkg::addr_t        w_addr,
    input  wire l1d_pkg::dword_t       w_data,
    input  wire l1d_pkg::access_size_t w_size,
    input  wire logic                  hit,
    input  wire l1d_pkg::way_t         hit_way,
    input  wire l1d_pkg::dword_t       hit_dword,
    input  wire l1d_pkg::way_t         victim_way,
    input  wire logic                  victim_dirty,
    input  wire l1d_pkg::tag_t         victim_tag,
    input  wire l1d_pkg::line_t        victim_line,
    input  wire logic                  xfer_done,
    input  wire l1d_pkg::line_t        fill_line,
    output logic                       req_ready,
    output logic                       r_data_valid,
    output l1d_pkg::dword_t            r_data,
    output logic                       w_complete,
    output l1d_pkg::addr_t             lookup_addr,
    output logic                       fill_en,
    output l1d_pkg::way_t              fill_way,
    output logic                       write_en,
    output l1d_pkg::way_t              write_way,
    output l1d_pkg::dword_t            write_data,
    output l1d_pkg::access_size_t      write_size,
    output logic                       start_read,
    output logic                       start_write,
    output l1d_pkg::addr_t             xfer_addr,
    output l1d_pkg::line_t             xfer_line
);

    typedef enum logic [2:0] {
        s_idle,
        s_lookup,       // Tag compare on the latched request
        s_writeback,    // Dirty victim going out to L2
        s_refill,       // Line coming in from L2
        s_relookup,     // Hit on the refilled line, then finish as a hit
        s_respond       // Completion pulse
    } state_t;

    state_t                state, next_state;

    // Latched request
    logic                  req_write;
    l1d_pkg::addr_t        req_addr;
    l1d_pkg::dword_t       req_data;
    l1d_pkg::access_size_t req_size;
    l1d_pkg::way_t         req_way;    // Way chosen for the refill

    logic                  accept_rd;
    logic                  accept_wr;
    logic                  lookup_hit;
    logic                  miss;
    logic [2:0]            dword_sel;

    // Read has priority when both ports are valid
    assign accept_rd  = req_ready && r_addr_valid;
    assign accept_wr  = req_ready && w_valid && !r_addr_valid;

    assign lookup_hit = ((state == s_lookup) || (state == s_relookup)) && hit;
    assign miss       = (state == s_lookup) && !hit;
    assign dword_sel  = req_addr[`L1D_OFFSET_W-1:3];

    always_comb begin
        next_state = state;
        case (state)
            s_idle:      if (accept_rd || accept_wr) next_state = s_lookup;
            s_lookup: begin
                if (hit)               next_state = s_respond;
                else if (victim_dirty) next_state = s_writeback;
                else                   next_state = s_refill;
            end
            s_writeback: if (xfer_done) next_state = s_refill;
            s_refill:    if (xfer_done) next_state = s_relookup;
            s_relookup:  next_state = s_respond;
            s_respond:   next_state = s_idle;
            default:     next_state = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= s_idle;
            req_ready <= 1'b0;
        end else begin
            state     <= next_state;
            req_ready <= (next_state == s_idle);  // Back up the cycle after completion
        end
    end

    always_ff @(posedge clk) begin
        if (accept_rd || accept_wr) begin
            req_write <= accept_wr;
            req_addr  <= accept_rd ? r_addr : w_addr;
            req_data  <= w_data;
            req_size  <= w_size;
        end
        if (miss) req_way <= victim_way;                    // Refill replaces the victim
        if (lookup_hit && !req_write) r_data <= hit_dword;
    end

    assign r_data_valid = (state == s_respond) && !req_write;
    assign w_complete   = (state == s_respond) && req_write;

    // Line store side
    assign lookup_addr = req_addr;
    assign write_en    = lookup_hit && req_write;
    assign write_way   = hit_way;
    assign write_data  = req_data;
    assign write_size  = req_size;
    assign fill_en     = (state == s_refill) && xfer_done;
    assign fill_way    = req_way;

    // Write-back first, then the refill of the same way
    assign start_write = miss && victim_dirty;
    assign start_read  = (miss && !victim_dirty) || ((state == s_writeback) && xfer_done);

    // The L2 port registers the victim on start_write
    assign xfer_addr = start_write
                     ? l1d_pkg::line_base(victim_tag, l1d_pkg::addr_index(req_addr))
                     : req_addr;
    assign xfer_line = victim_line;

    a_one_completion: assert property (@(posedge clk) disable iff (reset)
        !(r_data_valid && w_complete));

    a_read_aligned: assert property (@(posedge clk) disable iff (reset)
        lookup_hit && !req_write |-> req_addr[2:0] == 3'b000);

    // Refilled line must be visible to the re-lookup
    a_refill_hit: assert property (@(posedge clk) disable iff (reset)
        fill_en |=> hit && (req_write ||
            hit_dword == fill_line[dword_sel * `L1D_DWORD_W +: `L1D_DWORD_W]));

endmodule

`default_nettype wire

//--- verilog/l1d_l2_port.sv
`default_nettype none

module l1d_l2_port (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           start_read,
    input  wire logic           start_write,
    input  wire l1d_pkg::addr_t xfer_addr,
    input  wire l1d_pkg::line_t xfer_line,
    input  wire logic           l2_r_data_valid,
    input  wire l1d_pkg::line_t l2_r_data,
    input  wire logic           l2_w_complete,
    output logic                l2_r_addr_valid,
    output l1d_pkg::addr_t      l2_r_addr,
    output logic                l2_w_valid,
    output l1d_pkg::addr_t      l2_w_addr,
    output l1d_pkg::line_t      l2_w_data,
    output logic                xfer_done,
    output l1d_pkg::line_t      fill_line
);

    l1d_pkg::addr_t line_addr;
    logic           busy;
    logic           rd_done;
    logic           wr_done;

    assign line_addr = l1d_pkg::line_base(l1d_pkg::addr_tag(xfer_addr),
                                          l1d_pkg::addr_index(xfer_addr));

    assign busy    = l2_r_addr_valid || l2_w_valid;
    assign rd_done = l2_r_addr_valid && l2_r_data_valid;   // Response cycle
    assign wr_done = l2_w_valid && l2_w_complete;

    // Valids are held until L2 answers, dropped on the next edge
    always_ff @(posedge clk) begin
        if (reset) begin
            l2_r_addr_valid <= 1'b0;
            l2_w_valid      <= 1'b0;
            xfer_done       <= 1'b0;
        end else begin
            xfer_done <= rd_done || wr_done;
            if (start_read)
                l2_r_addr_valid <= 1'b1;
            else if (rd_done)
                l2_r_addr_valid <= 1'b0;
            if (start_write)
                l2_w_valid <= 1'b1;
            else if (wr_done)
                l2_w_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_read) l2_r_addr <= line_addr;
        if (start_write) begin
            l2_w_addr <= line_addr;
            l2_w_data <= xfer_line;     // Victim snapshot
        end
        if (rd_done) fill_line <= l2_r_data;   // Stays put until the next refill
    end

    // One line transfer at a time
    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        (start_read || start_write) |-> !busy && !(start_read && start_write));

endmodule

`default_nettype wire

//--- verilog/l1d_line_store.sv
`default_nettype none

`include "l1d_config.svh"

module l1d_line_store (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire l1d_pkg::addr_t        lookup_addr,
    input  wire logic                  fill_en,
    input  wire l1d_pkg::way_t         fill_way,
    input  wire l1d_pkg::line_t        fill_line,
    input  wire logic                  write_en,
    input  wire l1d_pkg::way_t         write_way,
    input  wire l1d_pkg::dword_t       write_data,
    input  wire l1d_pkg::access_size_t write_size,
    output logic                       hit,
    output l1d_pkg::way_t              hit_way,
    output l1d_pkg::dword_t            hit_dword,
    output l1d_pkg::way_t              victim_way,
    output logic                       victim_dirty,
    output l1d_pkg::tag_t              victim_tag,
    output l1d_pkg::line_t             victim_line
);

    l1d_pkg::tag_t              tag_mem  [`L1D_WAYS][`L1D_SETS];
    l1d_pkg::line_t             data_mem [`L1D_WAYS][`L1D_SETS];
    logic [`L1D_SETS-1:0]       valid    [`L1D_WAYS];
    logic [`L1D_SETS-1:0]       dirty    [`L1D_WAYS];
    logic                       rr_bit;     // Global round-robin victim

    l1d_pkg::index_t            idx;
    l1d_pkg::tag_t              tag;
    l1d_pkg::offset_t           off;
    logic [`L1D_WAYS-1:0]       way_hit;
    logic [7:0]                 lane_mask;
    logic [`L1D_LINE_BYTES-1:0] byte_en;
    l1d_pkg::line_t             wr_line;

    assign idx = l1d_pkg::addr_index(lookup_addr);
    assign tag = l1d_pkg::addr_tag(lookup_addr);
    assign off = l1d_pkg::addr_offset(lookup_addr);

    always_comb begin
        for (int w = 0; w < `L1D_WAYS; w++) begin
            way_hit[w] = valid[w][idx] && (tag_mem[w][idx] == tag);
        end
    end

    assign hit       = |way_hit;
    assign hit_way   = l1d_pkg::way_t'(!way_hit[0]);
    assign hit_dword = data_mem[hit_way][idx][off[`L1D_OFFSET_W-1:3] * `L1D_DWORD_W +: `L1D_DWORD_W];

    // Fill an empty way first, else take the round-robin way
    always_comb begin
        if (!valid[0][idx])      victim_way = 1'b0;
        else if (!valid[1][idx]) victim_way = 1'b1;
        else                     victim_way = rr_bit;
    end

    assign victim_dirty = valid[victim_way][idx] && dirty[victim_way][idx];
    assign victim_tag   = tag_mem[victim_way][idx];
    assign victim_line  = data_mem[victim_way][idx];

    // Low bytes of write_data land at the byte offset
    always_comb begin
        case (write_size)
            l1d_pkg::size_byte: lane_mask = 8'h01;
            l1d_pkg::size_half: lane_mask = 8'h03;
            l1d_pkg::size_word: lane_mask = 8'h0f;
            default:            lane_mask = 8'hff;
        endcase
        byte_en = {{(`L1D_LINE_BYTES - 8){1'b0}}, lane_mask} << off;
        wr_line = l1d_pkg::line_t'(write_data) << {off, 3'b000};
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fill_way][idx]  <= tag;
            data_mem[fill_way][idx] <= fill_line;
        end else if (write_en) begin
            for (int b = 0; b < `L1D_LINE_BYTES; b++) begin
                if (byte_en[b]) data_mem[write_way][idx][b*8 +: 8] <= wr_line[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `L1D_WAYS; w++) begin
                valid[w] <= '0;
                dirty[w] <= '0;
            end
            rr_bit <= 1'b0;
        end else if (fill_en) begin
            valid[fill_way][idx] <= 1'b1;
            dirty[fill_way][idx] <= 1'b0;
            if (valid[0][idx] && valid[1][idx]) rr_bit <= !rr_bit;
        end else if (write_en) begin
            dirty[write_way][idx] <= 1'b1;
        end
    end

    a_fill_write_excl: assert property (@(posedge clk) disable iff (reset)
        !(fill_en && write_en));

    a_write_in_line: assert property (@(posedge clk) disable iff (reset)
        write_en |-> (int'(off) + (1 << write_size)) <= `L1D_LINE_BYTES);

endmodule

`default_nettype wire

//--- verilog/l1d_pkg.sv
`default_nettype none

`include "l1d_config.svh"

package l1d_pkg;

    typedef logic [`L1D_ADDR_W-1:0]       addr_t;
    typedef logic [`L1D_DWORD_W-1:0]      dword_t;
    typedef logic [`L1D_LINE_W-1:0]       line_t;
    typedef logic [`L1D_TAG_W-1:0]        tag_t;
    typedef logic [`L1D_INDEX_W-1:0]      index_t;
    typedef logic [`L1D_OFFSET_W-1:0]     offset_t;
    typedef logic [$clog2(`L1D_WAYS)-1:0] way_t;

    // Write size as driven on w_size
    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_half  = 2'd1,
        size_word  = 2'd2,
        size_dword = 2'd3
    } access_size_t;

    function automatic tag_t addr_tag(addr_t addr);
        return addr[`L1D_ADDR_W-1 -: `L1D_TAG_W];
    endfunction

    function automatic index_t addr_index(addr_t addr);
        return addr[`L1D_OFFSET_W +: `L1D_INDEX_W];
    endfunction

    function automatic offset_t addr_offset(addr_t addr);
        return addr[`L1D_OFFSET_W-1:0];
    endfunction

    // Line-aligned address rebuilt from its fields
    function automatic addr_t line_base(tag_t tag, index_t index);
        return {tag, index, {`L1D_OFFSET_W{1'b0}}};
    endfunction

endpackage

`default_nettype wire
